/* vlog.f */
hdl/exec_pkg.sv
hdl/exec_uop_if.sv
hdl/exec_issue_queue.sv
hdl/exec_alu.sv
hdl/exec_ptr_step.sv
hdl/exec_eflags.sv
hdl/exec_branch.sv
hdl/exec_unit.sv
hdl/exec_top.sv
bench/exec_checker.sv
bench/exec_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e

verilator --binary --timing -j 0 --top-module exec_tb -f vlog.f -o exec_sim
./obj_dir/exec_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

/* bench/exec_tb.sv */
/*
 * Execute stage testbench
 * Table-driven micro-op stimulus under upstream credits, randomly
 * withheld downstream credits, drain and final report
 */
`timescale 1ns/1ns

module exec_tb import exec_pkg::*; ();

    localparam int ISSUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int TIMEOUT     = 200;   // Cycles allowed per wait

    typedef struct packed {
        opcode_t op;
        opsize_t size;
        word_t   a;
        word_t   b;
        word_t   ptr;
        word_t   eip;
        logic    pred_taken;
        word_t   pred_target;
        cond_t   cond;
    } row_t;

    logic    clk;
    logic    arst_n;
    logic    in_valid;
    opcode_t in_op;
    opsize_t in_size;
    word_t   in_a;
    word_t   in_b;
    word_t   in_ptr;
    word_t   in_eip;
    word_t   in_pred_target;
    logic    in_pred_taken;
    cond_t   in_cond;
    logic    in_credit;
    logic    out_credit;
    logic    out_valid;
    word_t   out_res;
    word_t   out_ptr;
    word_t   br_target;
    flags_t  out_flags;
    logic    out_df;
    logic    br_valid;
    logic    br_mispredict;
    int      value_errors;
    int      proto_errors;
    int      pending;
    row_t    table_q[$];
    int      up_credits;    // Upstream credits held by the producer
    int      owed;          // Downstream credits not yet handed back
    int      timeouts;

    exec_top #(
        .ISSUE_DEPTH(ISSUE_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) exec_top_inst (.*);

    exec_checker #(
        .ISSUE_DEPTH(ISSUE_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) checker_inst (.*);

    always #50 clk = ~clk;

    task automatic add_row(opcode_t op, opsize_t size, word_t a, word_t b, word_t ptr,
                           logic pt, word_t pt_tgt, cond_t cond);
        row_t r;
        r = '{op, size, a, b, ptr, 32'h1000 + 32'(4 * table_q.size()), pt, pt_tgt, cond};
        table_q.push_back(r);
    endtask

    task automatic alu_row(opcode_t op, opsize_t size, word_t a, word_t b);
        add_row(op, size, a, b, 32'h0000_8000, 1'b0, 32'h0, COND_Z);
    endtask

    task automatic ptr_row(opcode_t op, opsize_t size, word_t a, word_t ptr);
        add_row(op, size, a, 32'h5555_0000, ptr, 1'b0, 32'h0, COND_Z);
    endtask

    task automatic br_row(opcode_t op, cond_t cond, word_t tgt, logic pt, word_t pt_tgt);
        add_row(op, SZ_DWORD, 32'h0, tgt, 32'h0, pt, pt_tgt, cond);
    endtask

    task automatic build_table();
        alu_row(OP_CLD,  SZ_DWORD, 32'h0000_0000, 32'h0000_0000);
        alu_row(OP_ADD,  SZ_BYTE,  32'hdead_007f, 32'h0000_0001);   // Signed overflow
        alu_row(OP_ADD,  SZ_WORD,  32'h0001_ffff, 32'h0000_0001);   // Carry, zero
        alu_row(OP_ADD,  SZ_DWORD, 32'h7fff_fff0, 32'h0000_0020);
        alu_row(OP_SUB,  SZ_BYTE,  32'h0000_0010, 32'h0000_0020);
        alu_row(OP_SUB,  SZ_WORD,  32'h0000_8000, 32'h0000_0001);
        alu_row(OP_SUB,  SZ_DWORD, 32'h1234_5678, 32'h1234_5678);
        alu_row(OP_CMP,  SZ_DWORD, 32'h0000_0003, 32'h0000_0007);
        alu_row(OP_AND,  SZ_BYTE,  32'h1234_56f0, 32'h0000_003c);
        alu_row(OP_AND,  SZ_WORD,  32'hffff_f0f0, 32'h0000_0f0f);
        alu_row(OP_AND,  SZ_DWORD, 32'h8000_00ff, 32'hf000_0f0f);
        alu_row(OP_OR,   SZ_BYTE,  32'h0000_0000, 32'h0000_0100);
        alu_row(OP_OR,   SZ_WORD,  32'h0000_8001, 32'h0000_0410);
        alu_row(OP_OR,   SZ_DWORD, 32'h0f0f_0000, 32'h0000_f0f0);
        alu_row(OP_XOR,  SZ_BYTE,  32'h0000_00a5, 32'h0000_00a5);
        alu_row(OP_XOR,  SZ_WORD,  32'h0000_ff00, 32'h0000_0ff0);
        alu_row(OP_XOR,  SZ_DWORD, 32'hffff_ffff, 32'h0000_0001);
        alu_row(OP_SHL,  SZ_BYTE,  32'h0000_0081, 32'h0000_0001);
        alu_row(OP_SHL,  SZ_WORD,  32'h0000_4001, 32'h0000_0002);
        alu_row(OP_SHL,  SZ_DWORD, 32'h8000_0001, 32'h0000_0004);
        alu_row(OP_SAR,  SZ_BYTE,  32'h0000_0080, 32'h0000_0003);
        alu_row(OP_SAR,  SZ_WORD,  32'h0000_7ff0, 32'h0000_0004);
        alu_row(OP_SAR,  SZ_DWORD, 32'hf000_0000, 32'h0000_0008);
        ptr_row(OP_MOVS, SZ_BYTE,  32'h0, 32'h0000_2000);          // DF clear, upward
        ptr_row(OP_MOVS, SZ_WORD,  32'h0, 32'h0000_2001);
        ptr_row(OP_MOVS, SZ_DWORD, 32'h0, 32'h0000_2003);
        alu_row(OP_STD,  SZ_DWORD, 32'h0000_0000, 32'h0000_0000);
        ptr_row(OP_MOVS, SZ_BYTE,  32'h0, 32'h0000_3000);          // DF set, downward
        ptr_row(OP_MOVS, SZ_WORD,  32'h0, 32'h0000_2fff);
        ptr_row(OP_MOVS, SZ_DWORD, 32'h0, 32'h0000_2ffd);
        alu_row(OP_CMP,  SZ_BYTE,  32'h0000_0080, 32'h0000_0001);  // DF must survive
        alu_row(OP_CLD,  SZ_DWORD, 32'h0000_0000, 32'h0000_0000);
        ptr_row(OP_PUSH, SZ_DWORD, 32'hcafe_f00d, 32'h0000_7ff0);
        ptr_row(OP_POP,  SZ_WORD,  32'hdead_beef, 32'h0000_7fec);  // Full a, not sized
        ptr_row(OP_XCHG, SZ_DWORD, 32'h1111_1111, 32'h0000_0000);
        alu_row(OP_SUB,  SZ_DWORD, 32'h0000_0005, 32'h0000_0005);  // ZF for the JCCs
        br_row(OP_JCC, COND_Z,  32'h0000_4000, 1'b1, 32'h0000_4000);
        br_row(OP_JCC, COND_NZ, 32'h0000_4100, 1'b1, 32'h0000_4100);
        alu_row(OP_CMP,  SZ_DWORD, 32'h0000_0001, 32'h0000_0002);  // CF for the JCCs
        br_row(OP_JCC, COND_C,  32'h0000_4200, 1'b1, 32'h0000_4204);
        br_row(OP_JCC, COND_NC, 32'h0000_4300, 1'b0, 32'h0000_0000);
        br_row(OP_JMP, COND_Z,  32'h0000_5000, 1'b0, 32'h0000_0000);
        br_row(OP_JMP, COND_Z,  32'h0000_6000, 1'b1, 32'h0000_6000);
        // Random ALU burst at mixed sizes
        for (int k = 0; k < 24; k++) begin
            alu_row(opcode_t'(k % 8), opsize_t'(k % 3), $urandom, $urandom);
        end
    endtask

    // One clock, then producer and consumer act 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (in_credit) up_credits++;
        if (out_valid) owed++;
        if (owed > 0 && ($urandom % 5) < 2) begin
            out_credit = 1'b1;
            owed--;
        end else begin
            out_credit = 1'b0;
        end
    endtask

    task automatic drive(row_t r);
        in_op          = r.op;
        in_size        = r.size;
        in_a           = r.a;
        in_b           = r.b;
        in_ptr         = r.ptr;
        in_eip         = r.eip;
        in_pred_taken  = r.pred_taken;
        in_pred_target = r.pred_target;
        in_cond        = r.cond;
        in_valid       = 1'b1;
    endtask

    task automatic send_all();
        int waited;
        foreach (table_q[i]) begin
            waited = 0;
            while (up_credits == 0 && waited < TIMEOUT) begin
                next_cycle();
                waited++;
            end
            if (up_credits == 0) begin
                $display("Timeout: no upstream credit came back for micro-op %0d", i);
                timeouts++;
                return;
            end
            drive(table_q[i]);
            up_credits--;
            next_cycle();
        end
    endtask

    // Wait for every result and every upstream credit
    task automatic drain();
        int waited;
        waited = 0;
        while ((pending != 0 || up_credits != ISSUE_DEPTH) && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (pending != 0 || up_credits != ISSUE_DEPTH) begin
            $display("Timeout: drain incomplete, %0d results missing, %0d of %0d credits back",
                     pending, up_credits, ISSUE_DEPTH);
            timeouts++;
        end
    endtask

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_op          = OP_ADD;
        in_size        = SZ_DWORD;
        in_a           = 32'h0;
        in_b           = 32'h0;
        in_ptr         = 32'h0;
        in_eip         = 32'h0;
        in_pred_taken  = 1'b0;
        in_pred_target = 32'h0;
        in_cond        = COND_Z;
        out_credit     = 1'b0;
        up_credits     = ISSUE_DEPTH;
        owed           = 0;
        timeouts       = 0;
        void'($urandom(32'h1287dde0));
        build_table();
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        send_all();
        if (timeouts == 0) drain();
        $display("Error counts: value %0d, protocol %0d, timeout %0d",
                 value_errors, proto_errors, timeouts);
        if (value_errors == 0 && proto_errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* bench/exec_checker.sv */
/*
 * Execute stage checker
 * Reference model of results, flags and branch outcome kept in input
 * order, output comparison and credit accounting
 */
`timescale 1ns/1ns

module exec_checker import exec_pkg::*; #(
    parameter int ISSUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  opcode_t in_op,
    input  opsize_t in_size,
    input  word_t   in_a,
    input  word_t   in_b,
    input  word_t   in_ptr,
    input  word_t   in_eip,
    input  logic    in_pred_taken,
    input  word_t   in_pred_target,
    input  cond_t   in_cond,
    input  logic    in_credit,
    input  logic    out_credit,
    input  logic    out_valid,
    input  word_t   out_res,
    input  word_t   out_ptr,
    input  flags_t  out_flags,
    input  logic    out_df,
    input  logic    br_valid,
    input  logic    br_mispredict,
    input  word_t   br_target,
    output int      value_errors,
    output int      proto_errors,
    output int      pending
);

    typedef struct packed {
        opcode_t op;
        word_t   res;
        word_t   ptr;
        flags_t  flags;
        logic    df;
        logic    brv;
        logic    miss;
        word_t   tgt;
    } expect_t;

    expect_t exp_q[$];
    flags_t  m_flags;       // Architectural flags after the last accepted uop
    logic    m_df;
    int      accepted;
    int      credits_back;
    int      out_seen;
    int      credits_given;
    int      uop_idx;

    // x86 arithmetic, logic and shift semantics at the operand size
    function automatic void model_alu(input opcode_t op, input opsize_t size,
                                      input word_t a, input word_t b, input logic cf_in,
                                      output word_t res, output flags_t fl);
        int                 nb;
        word_t              mask;
        word_t              a_m;
        word_t              b_m;
        logic [32:0]        wide;
        logic [4:0]         cnt;
        logic signed [31:0] sx;
        word_t              last;
        nb   = (size == SZ_BYTE) ? 8 : (size == SZ_WORD) ? 16 : 32;
        mask = (nb == 32) ? 32'hffff_ffff : (32'd1 << nb) - 32'd1;
        a_m  = a & mask;
        b_m  = b & mask;
        cnt  = b[4:0];
        res  = a_m;
        fl   = '0;
        case (op)
            OP_ADD: begin
                wide      = {1'b0, a_m} + {1'b0, b_m};
                res       = wide[31:0] & mask;
                fl[FL_CF] = wide[nb];
                fl[FL_OF] = (a_m[nb-1] == b_m[nb-1]) && (res[nb-1] != a_m[nb-1]);
                fl[FL_AF] = a_m[4] ^ b_m[4] ^ res[4];
            end
            OP_SUB, OP_CMP: begin
                wide      = {1'b0, a_m} - {1'b0, b_m};
                res       = wide[31:0] & mask;
                fl[FL_CF] = (a_m < b_m);                 // Borrow
                fl[FL_OF] = (a_m[nb-1] != b_m[nb-1]) && (res[nb-1] != a_m[nb-1]);
                fl[FL_AF] = a_m[4] ^ b_m[4] ^ res[4];
            end
            OP_AND: res = a_m & b_m;
            OP_OR:  res = a_m | b_m;
            OP_XOR: res = a_m ^ b_m;
            OP_SHL: begin
                wide      = {1'b0, a_m} << cnt;
                res       = wide[31:0] & mask;
                fl[FL_CF] = (cnt == 5'd0) ? cf_in : wide[nb];
                fl[FL_OF] = res[nb-1] ^ fl[FL_CF];
            end
            OP_SAR: begin
                sx        = a_m[nb-1] ? (a_m | ~mask) : a_m;
                res       = word_t'(sx >>> cnt) & mask;
                last      = word_t'(sx >>> (cnt - 5'd1));  // Last bit shifted out in bit 0
                fl[FL_CF] = (cnt == 5'd0) ? cf_in : last[0];
            end
            default: ;
        endcase
        fl[FL_PF] = ~^res[7:0];
        fl[FL_ZF] = (res == 32'd0);
        fl[FL_SF] = res[nb-1];
    endfunction

    // Arithmetic and logic ops write every flag, shifts all but AF
    function automatic flags_t flags_written(opcode_t op);
        logic arith;
        logic shift;
        arith = (op == OP_ADD) || (op == OP_SUB) || (op == OP_CMP)
                || (op == OP_AND) || (op == OP_OR) || (op == OP_XOR);
        shift = (op == OP_SHL) || (op == OP_SAR);
        if (arith) return 6'b111111;
        if (shift) return ~(flags_t'(1) << FL_AF);
        return 6'b000000;
    endfunction

    task automatic record_uop();
        expect_t e;
        word_t   alu_r;
        flags_t  raw;
        flags_t  wr;
        word_t   step;
        logic    cond_ok;
        logic    taken;
        model_alu(in_op, in_size, in_a, in_b, m_flags[FL_CF], alu_r, raw);
        case (in_op)
            OP_XCHG:         e.res = in_b;
            OP_PUSH, OP_POP: e.res = in_a;
            default:         e.res = alu_r;
        endcase
        step = (in_size == SZ_BYTE) ? 32'd1 : (in_size == SZ_WORD) ? 32'd2 : 32'd4;
        case (in_op)
            OP_MOVS: e.ptr = m_df ? in_ptr - step : in_ptr + step;
            OP_PUSH: e.ptr = in_ptr - step;
            OP_POP:  e.ptr = in_ptr + step;
            OP_XCHG: e.ptr = in_a;
            default: e.ptr = in_ptr;
        endcase
        case (in_cond)
            COND_Z:  cond_ok = m_flags[FL_ZF];
            COND_NZ: cond_ok = !m_flags[FL_ZF];
            COND_C:  cond_ok = m_flags[FL_CF];
            default: cond_ok = !m_flags[FL_CF];
        endcase
        e.brv  = (in_op == OP_JMP) || (in_op == OP_JCC);
        taken  = (in_op == OP_JMP) || ((in_op == OP_JCC) && cond_ok);
        e.tgt  = taken ? in_b : in_eip + 32'd4;
        e.miss = e.brv && ((taken != in_pred_taken) || (taken && (in_b != in_pred_target)));
        // Flags advance in input order
        wr      = flags_written(in_op);
        m_flags = (m_flags & ~wr) | (raw & wr);
        if (in_op == OP_STD) m_df = 1'b1;
        if (in_op == OP_CLD) m_df = 1'b0;
        e.op    = in_op;
        e.flags = m_flags;
        e.df    = m_df;
        exp_q.push_back(e);
    endtask

    task automatic check_val(string name, word_t got, word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t ns: uop %0d %s got 0x%h expected 0x%h",
                     $time, uop_idx, name, got, exp);
        end
    endtask

    task automatic compare_result();
        expect_t e;
        if (exp_q.size() == 0) begin
            proto_errors++;
            $display("Result at %0t ns came with no micro-op outstanding", $time);
            return;
        end
        e = exp_q.pop_front();
        if (e.op != OP_CMP) check_val("out_res", out_res, e.res);   // CMP result unused
        check_val("out_ptr", out_ptr, e.ptr);
        check_val("out_flags", word_t'(out_flags), word_t'(e.flags));
        check_val("out_df", word_t'(out_df), word_t'(e.df));
        check_val("br_valid", word_t'(br_valid), word_t'(e.brv));
        check_val("br_mispredict", word_t'(br_mispredict), word_t'(e.miss));
        if (e.brv) check_val("br_target", br_target, e.tgt);
        uop_idx++;
    endtask

    // Inputs and results sampled mid-cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            m_flags       = '0;
            m_df          = 1'b0;
            accepted      = 0;
            credits_back  = 0;
            out_seen      = 0;
            credits_given = 0;
            uop_idx       = 0;
            value_errors  = 0;
            proto_errors  = 0;
            exp_q.delete();
        end else begin
            if (in_valid) begin
                accepted++;
                record_uop();
            end
            if (in_credit) credits_back++;
            if (out_credit) credits_given++;
            if (out_valid) begin
                out_seen++;
                compare_result();
            end
            if (credits_back > accepted) begin
                proto_errors++;
                $display("At %0t ns %0d upstream credits returned for only %0d micro-ops",
                         $time, credits_back, accepted);
            end
            if (out_seen > OUT_CREDITS + credits_given) begin
                proto_errors++;
                $display("At %0t ns %0d results sent with only %0d downstream credits",
                         $time, out_seen, OUT_CREDITS + credits_given);
            end
            if (accepted - out_seen > ISSUE_DEPTH + 1) begin
                proto_errors++;
                $display("At %0t ns %0d micro-ops in flight, more than the stage holds",
                         $time, accepted - out_seen);
            end
        end
        pending = exp_q.size();
    end

endmodule

/* hdl/exec_top.sv */
/*
 * Execute stage top level
 * Issue queue feeding the execute unit over the uop link
 */
`timescale 1ns/1ns

module exec_top import exec_pkg::*; #(
    parameter int ISSUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  opcode_t in_op,
    input  opsize_t in_size,
    input  word_t   in_a,
    input  word_t   in_b,
    input  word_t   in_ptr,
    input  word_t   in_eip,
    input  logic    in_pred_taken,
    input  word_t   in_pred_target,
    input  cond_t   in_cond,
    output logic    in_credit,
    input  logic    out_credit,
    output logic    out_valid,
    output word_t   out_res,
    output word_t   out_ptr,
    output flags_t  out_flags,
    output logic    out_df,
    output logic    br_valid,
    output logic    br_mispredict,
    output word_t   br_target
);

    exec_uop_if uop_bus ();

    exec_issue_queue #(
        .ISSUE_DEPTH(ISSUE_DEPTH)
    ) queue_inst (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_op(in_op),
        .in_size(in_size), .in_a(in_a), .in_b(in_b), .in_ptr(in_ptr),
        .in_eip(in_eip), .in_pred_taken(in_pred_taken),
        .in_pred_target(in_pred_target), .in_cond(in_cond),
        .in_credit(in_credit), .uop(uop_bus)
    );

    exec_unit #(
        .OUT_CREDITS(OUT_CREDITS)
    ) unit_inst (
        .clk(clk), .arst_n(arst_n), .uop(uop_bus), .out_credit(out_credit),
        .out_valid(out_valid), .out_res(out_res), .out_ptr(out_ptr),
        .out_flags(out_flags), .out_df(out_df), .br_valid(br_valid),
        .br_mispredict(br_mispredict), .br_target(br_target)
    );

endmodule

/* hdl/exec_unit.sv */
/*
 * Execute unit
 * Downstream credit counter, ALU, pointer, flag and branch logic
 * and the one-cycle output register
 */
`timescale 1ns/1ns

module exec_unit import exec_pkg::*; #(
    parameter int OUT_CREDITS = 2
) (
    input  logic    clk,
    input  logic    arst_n,
    exec_uop_if.sink uop,
    input  logic    out_credit,
    output logic    out_valid,
    output word_t   out_res,
    output word_t   out_ptr,
    output flags_t  out_flags,
    output logic    out_df,
    output logic    br_valid,
    output logic    br_mispredict,
    output word_t   br_target
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] credits;
    logic          take;
    word_t         alu_res;
    word_t         ptr_res;
    flags_t        flags_raw;
    logic          br_hit;
    logic          br_miss;
    word_t         next_ip;

    assign take     = uop.valid && (credits != '0);
    assign uop.take = take;

    exec_alu alu_inst (
        .op(uop.op), .size(uop.size), .a(uop.a), .b(uop.b),
        .cf_in(out_flags[FL_CF]), .res(alu_res), .flags_raw(flags_raw)
    );

    exec_ptr_step ptr_inst (
        .op(uop.op), .size(uop.size), .df(out_df), .a(uop.a),
        .ptr(uop.ptr), .ptr_res(ptr_res)
    );

    // Register holds the post-update flags while out_valid is high
    exec_eflags eflags_inst (
        .clk(clk), .arst_n(arst_n), .update(take), .mask(flag_mask(uop.op)),
        .flags_raw(flags_raw), .set_df(take && (uop.op == OP_STD)),
        .clr_df(take && (uop.op == OP_CLD)), .flags(out_flags), .df(out_df)
    );

    exec_branch branch_inst (
        .op(uop.op), .cond(uop.cond), .flags(out_flags), .eip(uop.eip),
        .target(uop.b), .pred_taken(uop.pred_taken), .pred_target(uop.pred_target),
        .br_valid(br_hit), .mispredict(br_miss), .next_ip(next_ip)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits       <= CW'(OUT_CREDITS);
            out_valid     <= 1'b0;
            br_valid      <= 1'b0;
            br_mispredict <= 1'b0;
        end else begin
            case ({take, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;    // Spend and return cancel
            endcase
            out_valid     <= take;
            br_valid      <= take && br_hit;
            br_mispredict <= take && br_miss;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (uop.op)
                OP_XCHG:        out_res <= uop.b;
                OP_PUSH, OP_POP: out_res <= uop.a;
                default:        out_res <= alu_res;
            endcase
            out_ptr   <= ptr_res;
            br_target <= next_ip;
        end
    end

endmodule

/* hdl/exec_branch.sv */
/*
 * Branch resolution
 * Evaluates JMP and JCC against current flags, picks the next IP
 * and compares with the front end prediction
 */
`timescale 1ns/1ns

module exec_branch import exec_pkg::*; (
    input  opcode_t op,
    input  cond_t   cond,
    input  flags_t  flags,
    input  word_t   eip,
    input  word_t   target,
    input  logic    pred_taken,
    input  word_t   pred_target,
    output logic    br_valid,
    output logic    mispredict,
    output word_t   next_ip
);

    logic cond_ok;
    logic taken;

    always_comb begin
        case (cond)
            COND_Z:  cond_ok = flags[FL_ZF];
            COND_NZ: cond_ok = ~flags[FL_ZF];
            COND_C:  cond_ok = flags[FL_CF];
            default: cond_ok = ~flags[FL_CF];
        endcase
    end

    assign br_valid   = (op == OP_JMP) || (op == OP_JCC);
    assign taken      = (op == OP_JMP) || ((op == OP_JCC) && cond_ok);
    assign next_ip    = taken ? target : eip + 32'd4;   // Fall through past the branch
    assign mispredict = br_valid
                        && ((taken != pred_taken) || (taken && (target != pred_target)));

endmodule

/* hdl/exec_eflags.sv */
/*
 * Flag register
 * Masked load of the arithmetic flags, direction flag set and clear
 */
`timescale 1ns/1ns

module exec_eflags import exec_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   update,
    input  flags_t mask,
    input  flags_t flags_raw,
    input  logic   set_df,
    input  logic   clr_df,
    output flags_t flags,
    output logic   df
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
            df    <= 1'b0;
        end else begin
            if (update) begin
                flags <= (flags & ~mask) | (flags_raw & mask);  // Unmasked bits kept
            end
            if (set_df) begin
                df <= 1'b1;
            end else if (clr_df) begin
                df <= 1'b0;
            end
        end
    end

endmodule

/* hdl/exec_ptr_step.sv */
/*
 * Pointer and stack result
 * String step by size and direction, push and pop adjustment,
 * exchange partner value
 */
`timescale 1ns/1ns

module exec_ptr_step import exec_pkg::*; (
    input  opcode_t op,
    input  opsize_t size,
    input  logic    df,
    input  word_t   a,
    input  word_t   ptr,
    output word_t   ptr_res
);

    word_t step;

    always_comb begin
        case (size)
            SZ_BYTE: step = 32'd1;
            SZ_WORD: step = 32'd2;
            default: step = 32'd4;
        endcase
    end

    always_comb begin
        case (op)
            OP_MOVS: ptr_res = df ? ptr - step : ptr + step;  // Down when DF set
            OP_PUSH: ptr_res = ptr - step;                    // Stack grows down
            OP_POP:  ptr_res = ptr + step;
            OP_XCHG: ptr_res = a;
            default: ptr_res = ptr;
        endcase
    end

endmodule

/* hdl/exec_alu.sv */
/*
 * Execute ALU
 * Add, subtract, logic and shifts at byte, word or dword size,
 * with raw carry, parity, adjust, zero, sign and overflow
 */
`timescale 1ns/1ns

module exec_alu import exec_pkg::*; (
    input  opcode_t op,
    input  opsize_t size,
    input  word_t   a,
    input  word_t   b,
    input  logic    cf_in,
    output word_t   res,
    output flags_t  flags_raw
);

    word_t              mask;
    word_t              sign_bit;
    word_t              am;
    word_t              bm;
    word_t              res_w;
    logic [32:0]        sum;
    logic [32:0]        diff;
    logic [63:0]        shl_wide;
    logic signed [32:0] sar_in;
    logic signed [32:0] sar_out;
    logic [4:0]         cnt;
    logic               cf;
    logic               of;
    logic               af;

    // Top bit of v at the current size
    function automatic logic msb(word_t v, word_t sb);
        return |(v & sb);
    endfunction

    always_comb begin
        case (size)
            SZ_BYTE: begin mask = 32'h0000_00ff; sign_bit = 32'h0000_0080; end
            SZ_WORD: begin mask = 32'h0000_ffff; sign_bit = 32'h0000_8000; end
            default: begin mask = 32'hffff_ffff; sign_bit = 32'h8000_0000; end
        endcase
    end

    assign am       = a & mask;
    assign bm       = b & mask;
    assign cnt      = b[4:0];
    assign sum      = {1'b0, am} + {1'b0, bm};
    assign diff     = {1'b0, am} - {1'b0, bm};   // Bit 32 is the borrow
    assign shl_wide = {32'b0, am} << cnt;
    assign sar_in   = {am | (msb(am, sign_bit) ? ~mask : 32'b0), 1'b0};
    assign sar_out  = sar_in >>> cnt;             // Bit 0 holds last bit out

    always_comb begin
        res_w = a;
        cf    = 1'b0;
        of    = 1'b0;
        af    = 1'b0;
        case (op)
            OP_ADD: begin
                res_w = sum[31:0];
                cf    = |(sum & {sign_bit, 1'b0});
                of    = (msb(a, sign_bit) == msb(b, sign_bit))
                        && (msb(sum[31:0], sign_bit) != msb(a, sign_bit));
                af    = a[4] ^ b[4] ^ sum[4];
            end
            OP_SUB, OP_CMP: begin
                res_w = diff[31:0];
                cf    = diff[32];
                of    = (msb(a, sign_bit) != msb(b, sign_bit))
                        && (msb(diff[31:0], sign_bit) != msb(a, sign_bit));
                af    = a[4] ^ b[4] ^ diff[4];
            end
            OP_AND: res_w = am & bm;
            OP_OR:  res_w = am | bm;
            OP_XOR: res_w = am ^ bm;
            OP_SHL: begin
                res_w = shl_wide[31:0];
                cf    = (cnt == 5'd0) ? cf_in : |(shl_wide[32:0] & {sign_bit, 1'b0});
                of    = msb(shl_wide[31:0] & mask, sign_bit) ^ cf;
            end
            OP_SAR: begin
                res_w = sar_out[32:1];
                cf    = (cnt == 5'd0) ? cf_in : sar_out[0];
            end
            default: res_w = a;                   // Non-ALU ops pass a
        endcase
    end

    assign res               = res_w & mask;
    assign flags_raw[FL_CF]  = cf;
    assign flags_raw[FL_PF]  = ~^res[7:0];        // Even parity of low byte
    assign flags_raw[FL_AF]  = af;
    assign flags_raw[FL_ZF]  = (res == 32'b0);
    assign flags_raw[FL_SF]  = msb(res, sign_bit);
    assign flags_raw[FL_OF]  = of;

endmodule

/* hdl/exec_issue_queue.sv */
/*
 * Issue queue
 * Circular micro-op FIFO, head presented on the uop link,
 * one upstream credit returned per entry that leaves
 */
`timescale 1ns/1ns

module exec_issue_queue import exec_pkg::*; #(
    parameter int ISSUE_DEPTH = 4
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  opcode_t in_op,
    input  opsize_t in_size,
    input  word_t   in_a,
    input  word_t   in_b,
    input  word_t   in_ptr,
    input  word_t   in_eip,
    input  logic    in_pred_taken,
    input  word_t   in_pred_target,
    input  cond_t   in_cond,
    output logic    in_credit,
    exec_uop_if.source uop
);

    localparam int PW = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
    localparam int CW = $clog2(ISSUE_DEPTH + 1);
    localparam int EW = $bits(opcode_t) + $bits(opsize_t) + 5 * $bits(word_t) + 1
                        + $bits(cond_t);

    logic [EW-1:0] mem [ISSUE_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;

    assign pop = uop.valid & uop.take;
    assign uop.valid = (count != '0);
    assign {uop.op, uop.size, uop.a, uop.b, uop.ptr, uop.eip,
            uop.pred_taken, uop.pred_target, uop.cond} = mem[rd_ptr];

    // Credits upstream guarantee a free slot
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= {in_op, in_size, in_a, in_b, in_ptr, in_eip,
                            in_pred_taken, in_pred_target, in_cond};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PW'(ISSUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(ISSUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            in_credit <= pop;   // Slot freed, hand the credit back
        end
    end

endmodule

/* hdl/exec_uop_if.sv */
/*
 * Micro-op link from issue queue to execute unit
 * Valid/take handshake, one transfer per edge with both high
 */
`timescale 1ns/1ns

interface exec_uop_if import exec_pkg::*; ();

    logic    valid;
    opcode_t op;
    opsize_t size;
    word_t   a;
    word_t   b;
    word_t   ptr;          // Pointer or stack register value
    word_t   eip;
    logic    pred_taken;
    word_t   pred_target;
    cond_t   cond;
    logic    take;

    modport source (output valid, op, size, a, b, ptr, eip, pred_taken, pred_target, cond,
                    input take);

    modport sink (input valid, op, size, a, b, ptr, eip, pred_taken, pred_target, cond,
                  output take);

endinterface

/* hdl/exec_pkg.sv */
/*
 * Execute stage shared definitions
 * Data widths, micro-op codes, size and condition codes, flag
 * positions and the per-opcode flag update mask
 */
package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [1:0]  opsize_t;
    typedef logic [1:0]  cond_t;
    typedef logic [5:0]  flags_t;     // {of, sf, zf, af, pf, cf}

    localparam opcode_t OP_ADD  = 4'd0;
    localparam opcode_t OP_SUB  = 4'd1;
    localparam opcode_t OP_CMP  = 4'd2;
    localparam opcode_t OP_AND  = 4'd3;
    localparam opcode_t OP_OR   = 4'd4;
    localparam opcode_t OP_XOR  = 4'd5;
    localparam opcode_t OP_SHL  = 4'd6;
    localparam opcode_t OP_SAR  = 4'd7;
    localparam opcode_t OP_MOVS = 4'd8;
    localparam opcode_t OP_PUSH = 4'd9;
    localparam opcode_t OP_POP  = 4'd10;
    localparam opcode_t OP_XCHG = 4'd11;
    localparam opcode_t OP_JMP  = 4'd12;
    localparam opcode_t OP_JCC  = 4'd13;
    localparam opcode_t OP_CLD  = 4'd14;
    localparam opcode_t OP_STD  = 4'd15;

    localparam opsize_t SZ_BYTE  = 2'd0;
    localparam opsize_t SZ_WORD  = 2'd1;
    localparam opsize_t SZ_DWORD = 2'd2;

    localparam cond_t COND_Z  = 2'd0;
    localparam cond_t COND_NZ = 2'd1;
    localparam cond_t COND_C  = 2'd2;
    localparam cond_t COND_NC = 2'd3;

    // Bit positions inside flags_t
    localparam int FL_CF = 0;
    localparam int FL_PF = 1;
    localparam int FL_AF = 2;
    localparam int FL_ZF = 3;
    localparam int FL_SF = 4;
    localparam int FL_OF = 5;

    // Flags written by each opcode, all others are kept
    function automatic flags_t flag_mask(opcode_t op);
        case (op)
            OP_ADD, OP_SUB, OP_CMP,
            OP_AND, OP_OR, OP_XOR: return 6'b111111;
            OP_SHL, OP_SAR:        return 6'b111011;  // AF left alone
            default:               return 6'b000000;
        endcase
    endfunction

endpackage
